// ==== src/fps_pkg.sv ====
// ----------------------------------------
// F-PS shared definitions
// operation codes, job phases and the
// delay class of each phase step
// ----------------------------------------

`default_nettype none

package fps_pkg;

	// operation requested by the CPU
	typedef enum logic [1:0] {
		FP_AD = 2'd0,
		FP_SD = 2'd1,
		FP_MW = 2'd2,
		FP_DW = 2'd3
	} fp_op_t;

	// job phases, in the order a full job visits them
	typedef enum logic [2:0] {
		PH_IDLE  = 3'd0,
		PH_FETCH = 3'd1,
		PH_ALIGN = 3'd2,
		PH_ARITH = 3'd3,
		PH_NORM  = 3'd4,
		PH_STORE = 3'd5,
		PH_END   = 3'd6
	} fp_phase_t;

	// words per operand and per result
	localparam int FP_WORDS = 3;

	// arithmetic steps for multiply and divide
	localparam int FP_ITER_MD = 3;

	// gap between strob1 and strob2, in delay units
	function automatic logic [1:0] fp_dly_class(input fp_phase_t ph);
		logic [1:0] cls;
		case (ph)
			PH_FETCH: cls = 2'd1;
			PH_ALIGN: cls = 2'd2;
			PH_ARITH: cls = 2'd3;
			PH_NORM:  cls = 2'd2;
			PH_STORE: cls = 2'd1;
			default:  cls = 2'd0;
		endcase
		return cls;
	endfunction

endpackage

`default_nettype wire

// ==== src/fps_start.sv ====
// ----------------------------------------
// F-PS job start and end handshake
// accepts efp from the CPU, captures the
// operation and holds ekc_fp until puf drops
// ----------------------------------------

`default_nettype none

module fps_start import fps_pkg::*; (
	input  wire    got_fp,
	input  wire    _0_f,
	input  wire    efp,
	input  wire    puf,
	input  fp_op_t op,
	input  wire    nrf,
	input  wire    job_done,
	output logic   start,
	output logic   busy,
	output logic   ekc_fp,
	output fp_op_t op_q,
	output logic   nrf_q
);

	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_START = 2'd1,
		ST_RUN   = 2'd2,
		ST_WAIT  = 2'd3
	} st_t;

	st_t st;

	// a job is taken only when idle with the CPU holding puf
	logic accept;
	assign accept = (st == ST_IDLE) && efp && puf;

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			st <= ST_IDLE;
		end else begin
			case (st)
				ST_IDLE:  if (accept) st <= ST_START;
				ST_START: st <= ST_RUN;
				ST_RUN:   if (job_done) st <= ST_WAIT;
				ST_WAIT:  if (!puf) st <= ST_IDLE;
				default:  st <= ST_IDLE;
			endcase
		end
	end

	// job parameters, valid from the start pulse on
	always_ff @(posedge got_fp) begin
		if (accept) begin
			op_q  <= op;
			nrf_q <= nrf;
		end
	end

	assign start  = (st == ST_START);
	assign busy   = (st != ST_IDLE);
	assign ekc_fp = (st == ST_WAIT);

endmodule

`default_nettype wire

// ==== src/fp_strobgen.sv ====
// ----------------------------------------
// F-PS strobe generator
// paces every phase step with strob1 and
// strob2, plus memory and register requests
// ----------------------------------------

`default_nettype none

module fp_strobgen import fps_pkg::*; #(
	parameter int DLY_UNIT = 1
) (
	input  wire       got_fp,
	input  wire       _0_f,
	input  fp_phase_t phase,
	output logic      strob1,
	output logic      strob2,
	output logic      step_done,
	input  wire       oken,
	output logic      read_fp,
	output logic      rlp_fp
);

	// longest gap is class 3
	localparam int GAP_MAX = 3 * DLY_UNIT;
	localparam int GAP_W   = $clog2(GAP_MAX + 1);

	typedef enum logic [1:0] {
		ST_RDY = 2'd0,
		ST_GAP = 2'd1,
		ST_END = 2'd2
	} st_t;

	st_t             st;
	logic [GAP_W-1:0] gap_cnt;
	logic [GAP_W-1:0] gap_len;
	logic            is_fetch;
	logic            is_store;

	// phase only moves at step_done, so it is steady for a whole step
	assign is_fetch = (phase == PH_FETCH);
	assign is_store = (phase == PH_STORE);
	assign gap_len  = GAP_W'(fp_dly_class(phase) * DLY_UNIT);

	// ----------------------------------------
	// strobes
	// ----------------------------------------

	// new step whenever a job is on and nothing is running
	assign strob1 = (st == ST_RDY) && (phase != PH_IDLE);

	// fetch steps end only once memory answers
	assign strob2    = (st == ST_END) && (!is_fetch || oken);
	assign step_done = strob2;

	// read request spans the whole fetch step
	assign read_fp = is_fetch && (strob1 || (st == ST_GAP) || (st == ST_END));

	// register write request for each result word
	assign rlp_fp = strob1 && is_store;

	// ----------------------------------------
	// step timer
	// ----------------------------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			st      <= ST_RDY;
			gap_cnt <= '0;
		end else begin
			case (st)
				ST_RDY: begin
					if (strob1) begin
						if (gap_len != '0) begin
							st      <= ST_GAP;
							gap_cnt <= gap_len;
						end else begin
							st <= ST_END;
						end
					end
				end
				ST_GAP: begin
					gap_cnt <= gap_cnt - GAP_W'(1);
					if (gap_cnt == GAP_W'(1))
						st <= ST_END;
				end
				ST_END: begin
					// low oken simply stretches the step
					if (step_done)
						st <= ST_RDY;
				end
				default: st <= ST_RDY;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/fps_phase.sv ====
// ----------------------------------------
// F-PS phase register
// holds the job phase and picks the next
// one at the end of every step
// ----------------------------------------

`default_nettype none

module fps_phase import fps_pkg::*; (
	input  wire       got_fp,
	input  wire       _0_f,
	input  wire       start,
	input  fp_op_t    op_q,
	input  wire       nrf_q,
	input  wire       di,
	input  wire       step_done,
	input  wire       lp_last,
	output fp_phase_t phase,
	output logic      lp_load,
	output logic      lp_dec,
	output logic      job_done
);

	// single word or single step phases need no loop
	localparam bit WORD_LOOP = (FP_WORDS > 1);
	localparam bit ITER_LOOP = (FP_ITER_MD > 1);

	fp_phase_t next_ph;
	logic      advance;
	logic      is_md;
	logic      abort_q;
	logic      word_end;
	logic      iter_end;

	assign is_md    = (op_q == FP_MW) || (op_q == FP_DW);
	assign word_end = lp_last || !WORD_LOOP;
	assign iter_end = lp_last || !ITER_LOOP;

	// the register moves on start and at each step end
	assign advance = (phase == PH_IDLE) ? start : step_done;

	// ----------------------------------------
	// next phase
	// ----------------------------------------

	always_comb begin
		next_ph = phase;
		if (abort_q && (phase != PH_IDLE) && (phase != PH_END)) begin
			// interrupt cuts the job short
			next_ph = PH_END;
		end else begin
			case (phase)
				PH_IDLE:  next_ph = nrf_q ? PH_NORM : PH_FETCH;
				PH_FETCH: begin
					if (word_end)
						next_ph = is_md ? PH_ARITH : PH_ALIGN;
				end
				PH_ALIGN: next_ph = PH_ARITH;
				PH_ARITH: begin
					if (!is_md || iter_end)
						next_ph = PH_NORM;
				end
				PH_NORM:  next_ph = PH_STORE;
				PH_STORE: if (word_end) next_ph = PH_END;
				PH_END:   next_ph = PH_IDLE;
				default:  next_ph = PH_IDLE;
			endcase
		end
	end

	// load the word loop on entry to a looping phase
	always_comb begin
		lp_load = 1'b0;
		if (advance && (next_ph != phase)) begin
			case (next_ph)
				PH_FETCH: lp_load = 1'b1;
				PH_ARITH: lp_load = is_md;
				PH_STORE: lp_load = 1'b1;
				default:  lp_load = 1'b0;
			endcase
		end
	end

	// staying in a phase means one more word or iteration
	assign lp_dec = advance && (phase != PH_IDLE) && (next_ph == phase);

	assign job_done = step_done && (phase == PH_END);

	// ----------------------------------------
	// state
	// ----------------------------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			phase   <= PH_IDLE;
			abort_q <= 1'b0;
		end else begin
			if (advance)
				phase <= next_ph;
			if (job_done)
				abort_q <= 1'b0;
			else if (di && (phase != PH_IDLE))
				abort_q <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/fps_lp.sv ====
// ----------------------------------------
// F-PS word loop counter
// counts words and iterations down to one
// ----------------------------------------

`default_nettype none

module fps_lp import fps_pkg::*; (
	input  wire  got_fp,
	input  wire  _0_f,
	input  wire  lp_load,
	input  wire  lp_dec,
	output logic lpa,
	output logic lpb,
	output logic lp_last
);

	// one counter serves the word loop and the md iteration loop
	localparam int LP_INIT = (FP_WORDS > FP_ITER_MD) ? FP_WORDS : FP_ITER_MD;

	logic [1:0] cnt;

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			cnt <= 2'd0;
		end else if (lp_load) begin
			cnt <= 2'(LP_INIT);
		end else if (lp_dec) begin
			cnt <= cnt - 2'd1;
		end
	end

	// word index toward the register file
	assign lpb = cnt[1];
	assign lpa = cnt[0];

	assign lp_last = (cnt == 2'd1);

endmodule

`default_nettype wire

// ==== src/fps.sv ====
// ----------------------------------------
// F-PS control unit top
// job handshake, phase sequencer, step
// strobes and word loop
// ----------------------------------------

`default_nettype none

module fps import fps_pkg::*; #(
	parameter int DLY_UNIT = 1
) (
	input  wire    got_fp,
	input  wire    _0_f,
	// CPU side
	input  wire    efp,
	input  wire    puf,
	input  fp_op_t op,
	input  wire    nrf,
	input  wire    di,
	output logic   start,
	output logic   busy,
	output logic   ekc_fp,
	// memory side
	input  wire    oken,
	output logic   strob1,
	output logic   strob2,
	output logic   read_fp,
	output logic   rlp_fp,
	output logic   lpa,
	output logic   lpb
);

	fp_op_t    op_q;
	logic      nrf_q;
	logic      job_done;
	fp_phase_t phase;
	logic      lp_load;
	logic      lp_dec;
	logic      lp_last;
	logic      step_done;

	fps_start u_start (
		.got_fp   (got_fp),
		._0_f     (_0_f),
		.efp      (efp),
		.puf      (puf),
		.op       (op),
		.nrf      (nrf),
		.job_done (job_done),
		.start    (start),
		.busy     (busy),
		.ekc_fp   (ekc_fp),
		.op_q     (op_q),
		.nrf_q    (nrf_q)
	);

	fp_strobgen #(
		.DLY_UNIT (DLY_UNIT)
	) u_strobgen (
		.got_fp    (got_fp),
		._0_f      (_0_f),
		.phase     (phase),
		.strob1    (strob1),
		.strob2    (strob2),
		.step_done (step_done),
		.oken      (oken),
		.read_fp   (read_fp),
		.rlp_fp    (rlp_fp)
	);

	fps_phase u_phase (
		.got_fp    (got_fp),
		._0_f      (_0_f),
		.start     (start),
		.op_q      (op_q),
		.nrf_q     (nrf_q),
		.di        (di),
		.step_done (step_done),
		.lp_last   (lp_last),
		.phase     (phase),
		.lp_load   (lp_load),
		.lp_dec    (lp_dec),
		.job_done  (job_done)
	);

	fps_lp u_lp (
		.got_fp  (got_fp),
		._0_f    (_0_f),
		.lp_load (lp_load),
		.lp_dec  (lp_dec),
		.lpa     (lpa),
		.lpb     (lpb),
		.lp_last (lp_last)
	);

endmodule

`default_nettype wire

// ==== test/fps_sva.sv ====
// ----------------------------------------
// F-PS handshake and strobe assertions
// ----------------------------------------

`default_nettype none

module fps_sva (
	input wire got_fp,
	input wire _0_f,
	input wire start,
	input wire strob1,
	input wire strob2,
	input wire read_fp,
	input wire oken
);

	// assertion failures so far
	int err_cnt = 0;

	// strob1 opens a step and strob2 closes it
	logic step_open;

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f)
			step_open <= 1'b0;
		else if (strob1)
			step_open <= 1'b1;
		else if (strob2)
			step_open <= 1'b0;
	end

	// start is a single cycle pulse
	start_one_cycle: assert property (
		@(posedge got_fp) disable iff (_0_f) start |=> !start
	) else begin
		$error("start held longer than one cycle");
		err_cnt++;
	end

	strobes_apart: assert property (
		@(posedge got_fp) disable iff (_0_f)
		(strob1 || strob2) |-> (strob1 != strob2) && (step_open == strob2)
	) else begin
		$error("strob1 and strob2 out of order or high together");
		err_cnt++;
	end

	// memory request waits for oken
	read_until_oken: assert property (
		@(posedge got_fp) disable iff (_0_f) (read_fp && !oken) |=> read_fp
	) else begin
		$error("read_fp dropped before oken");
		err_cnt++;
	end

endmodule

`default_nettype wire

// ==== test/tb_fps.sv ====
// ----------------------------------------
// F-PS control unit testbench
// random jobs from an LCG, checked against
// a step model of the phase sequence
// ----------------------------------------

`default_nettype none

module tb_fps import fps_pkg::*; ();

	localparam int DLY_UNIT = 2;
	localparam int JOBS     = 40;
	// slowest job is md, every fetch waiting longest for oken
	localparam int JOB_MAX = 3 * (2 + DLY_UNIT + 4) + 3 * (2 + 3 * DLY_UNIT)
		+ (2 + 2 * DLY_UNIT) + 3 * (2 + DLY_UNIT) + 2 + 16;
	localparam int CYCLE_LIMIT = 8 + JOBS * JOB_MAX;

	logic        got_fp;
	logic        _0_f;
	logic        efp;
	logic        puf;
	fp_op_t      op;
	logic        nrf;
	logic        di;
	logic        oken;
	logic        start;
	logic        busy;
	logic        ekc_fp;
	logic        strob1;
	logic        strob2;
	logic        read_fp;
	logic        rlp_fp;
	logic        lpa;
	logic        lpb;

	int unsigned seed;
	int          cyc;
	fp_phase_t   exp_ph[$];
	fp_phase_t   cur;
	logic        in_step;
	int          step;
	int          s1_cyc;
	int          gap;
	int          n_start;
	int          n_s1;
	int          n_s2;
	int          n_rd;
	int          n_rlp;
	int          wcnt;
	int          oken_dly;

	fps #(.DLY_UNIT(DLY_UNIT)) DUT (.*);

	bind fps_start fps_sva u_sva (
		.got_fp  (got_fp),
		._0_f    (_0_f),
		.start   (start),
		.strob1  (1'b0),
		.strob2  (1'b0),
		.read_fp (1'b0),
		.oken    (1'b0)
	);

	bind fp_strobgen fps_sva u_sva (
		.got_fp  (got_fp),
		._0_f    (_0_f),
		.start   (1'b0),
		.strob1  (strob1),
		.strob2  (strob2),
		.read_fp (read_fp),
		.oken    (oken)
	);

	initial got_fp = 1'b0;
	always #2 got_fp = ~got_fp;

	// ----------------------------------------
	// model
	// ----------------------------------------

	function automatic logic [15:0] lcg();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[30:15];
	endfunction

	// strob1 to strob2 gap of each phase, in delay units
	function automatic int gap_units(input fp_phase_t ph);
		case (ph)
			PH_FETCH: return 1;
			PH_ALIGN: return 2;
			PH_ARITH: return 3;
			PH_NORM:  return 2;
			PH_STORE: return 1;
			default:  return 0;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			$display("ERROR %s expected %0d actual %0d", name, exp_v, act_v);
			$display("TESTS FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// expected phase of every step in one job
	task automatic predict_steps(input fp_op_t o, input logic n, input logic ab);
		fp_phase_t first;
		exp_ph.delete();
		if (!n) begin
			repeat (3)
				exp_ph.push_back(PH_FETCH);
			if (o == FP_AD || o == FP_SD)
				exp_ph.push_back(PH_ALIGN);
			repeat ((o == FP_MW || o == FP_DW) ? 3 : 1)
				exp_ph.push_back(PH_ARITH);
		end
		exp_ph.push_back(PH_NORM);
		repeat (3)
			exp_ph.push_back(PH_STORE);
		exp_ph.push_back(PH_END);
		// an abort ends the first step and only the end step follows
		if (ab) begin
			first = exp_ph[0];
			exp_ph.delete();
			exp_ph.push_back(first);
			exp_ph.push_back(PH_END);
		end
	endtask

	function automatic int count_steps(input fp_phase_t ph);
		int n;
		n = 0;
		foreach (exp_ph[i])
			if (exp_ph[i] == ph)
				n++;
		return n;
	endfunction

	// ----------------------------------------
	// monitor and timeout
	// ----------------------------------------

	always @(posedge got_fp) begin
		if (!_0_f) begin
			if (start)
				n_start++;
			if (strob1) begin
				check("steps_within_prediction", 1, step < exp_ph.size());
				cur = exp_ph[step];
				s1_cyc = cyc;
				in_step = 1'b1;
				check("rlp_fp_at_strob1", cur == PH_STORE, rlp_fp);
				if (cur == PH_FETCH)
					check("fetch_word_index", 3 - n_rd, {lpb, lpa});
				if (cur == PH_STORE)
					check("store_word_index", 3 - n_rlp, {lpb, lpa});
				n_s1++;
			end
			// memory request only inside a fetch step
			check("read_fp_in_fetch", in_step && cur == PH_FETCH, read_fp);
			if (read_fp && strob1)
				n_rd++;
			if (rlp_fp) begin
				check("rlp_fp_with_strob1", 1, strob1);
				n_rlp++;
			end
			if (strob2) begin
				gap = cyc - s1_cyc - 1;
				if (cur == PH_FETCH) begin
					check("fetch_strob2_oken", 1, oken);
					check("read_fp_held", 1, read_fp);
					check("fetch_gap_min", 1, gap >= gap_units(cur) * DLY_UNIT);
				end else begin
					check("step_gap", gap_units(cur) * DLY_UNIT, gap);
				end
				n_s2++;
				step++;
				in_step = 1'b0;
			end
		end
		cyc = cyc + 1;
		if (cyc > CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	// memory answers some cycles after each fetch strob1
	always @(negedge got_fp) begin
		if (strob1)
			wcnt = 0;
		else
			wcnt = wcnt + 1;
		oken = read_fp && (wcnt >= 2 + oken_dly);
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	initial begin
		logic [15:0] r;
		logic        ab;
		int          di_off;
		int          puf_dly;
		seed = 13399;
		cyc = 0;
		wcnt = 0;
		oken_dly = 0;
		in_step = 1'b0;
		_0_f = 1'b1;
		efp = 1'b0;
		puf = 1'b0;
		op = FP_AD;
		nrf = 1'b0;
		di = 1'b0;
		oken = 1'b0;
		repeat (4) @(negedge got_fp);
		check("outputs_in_reset", 0, {start, busy, ekc_fp, strob1, strob2, read_fp, rlp_fp});
		_0_f = 1'b0;
		for (int j = 0; j < JOBS; j++) begin
			r = lcg();
			op = fp_op_t'(r[1:0]);
			nrf = r[2];
			ab = (r[4:3] == 2'd0);
			r = lcg();
			di_off = r % 3;
			oken_dly = (r >> 4) % 4;
			puf_dly = (r >> 8) % 4;
			predict_steps(op, nrf, ab);
			step = 0;
			n_start = 0;
			n_s1 = 0;
			n_s2 = 0;
			n_rd = 0;
			n_rlp = 0;
			efp = 1'b1;
			puf = 1'b1;
			@(negedge got_fp);
			efp = 1'b0;
			check("start_after_efp", 1, start);
			check("busy_after_efp", 1, busy);
			if (ab) begin
				while (!strob1)
					@(negedge got_fp);
				repeat (di_off)
					@(negedge got_fp);
				di = 1'b1;
				@(negedge got_fp);
				di = 1'b0;
			end
			// second request while busy
			@(negedge got_fp);
			efp = 1'b1;
			op = fp_op_t'(op ^ 2'b11);
			@(negedge got_fp);
			efp = 1'b0;
			while (!ekc_fp)
				@(negedge got_fp);
			check("steps_before_ekc_fp", exp_ph.size(), n_s2);
			repeat (puf_dly) begin
				@(negedge got_fp);
				check("ekc_fp_held", 1, ekc_fp);
			end
			puf = 1'b0;
			@(negedge got_fp);
			check("ekc_fp_after_puf", 0, ekc_fp);
			check("idle_after_puf", 0, busy);
			check("start_pulses", 1, n_start);
			check("strob1_count", exp_ph.size(), n_s1);
			check("strob2_count", exp_ph.size(), n_s2);
			check("read_fp_count", count_steps(PH_FETCH), n_rd);
			check("rlp_fp_count", count_steps(PH_STORE), n_rlp);
		end
		check("start_assertions", 0, DUT.u_start.u_sva.err_cnt);
		check("strobe_assertions", 0, DUT.u_strobgen.u_sva.err_cnt);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
src/fps_pkg.sv
src/fps_start.sv
src/fp_strobgen.sv
src/fps_phase.sv
src/fps_lp.sv
src/fps.sv
test/fps_sva.sv
test/tb_fps.sv

// ==== Bender.yml ====
package:
  name: fps

sources:
  - src/fps_pkg.sv
  - src/fps_start.sv
  - src/fp_strobgen.sv
  - src/fps_phase.sv
  - src/fps_lp.sv
  - src/fps.sv
  - target: test
    files:
      - test/fps_sva.sv
      - test/tb_fps.sv
